/* Makefile */
TOP := tb_fpga_top
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
logic/board_pkg.sv
logic/io_pkg.sv
logic/sync_stage.sv
logic/hex_display.sv
logic/heartbeat.sv
logic/io_ctrl.sv
logic/fpga_top.sv
tb/tb_fpga_top.sv

/* logic/board_pkg.sv */
// Widths and pin types of a DE2-class board, with keys active high once the top level has inverted the pins
package board_pkg;

	// Pin counts
	localparam int num_red_leds = 18;	// Red LED bank
	localparam int num_green_leds = 9;	// Green LED bank
	localparam int num_switches = 18;	// Slide switches
	localparam int num_keys = 4;		// Push keys
	localparam int num_digits = 4;		// Seven-segment digits
	localparam int num_segments = 7;	// Segments per digit, no decimal point
	localparam int nibble_bits = 4;		// One hex digit
	localparam int hex_bits = num_digits * nibble_bits;	// Whole display value

	// Heartbeat counter width
	localparam int heartbeat_width = 24;	// Covers periods up to 16.7M cycles

	// LED drive vector, bit 0 is LEDR0
	typedef logic [num_red_leds-1:0] red_led_t;

	// Slide switch sample
	typedef logic [num_switches-1:0] sw_t;

	// Key sample, high while pressed
	typedef logic [num_keys-1:0] key_t;

	// Segment pattern in gfedcba order, active low
	typedef logic [num_segments-1:0] seg_t;

	// Four nibbles, digit 0 in the low nibble
	typedef logic [num_digits-1:0][nibble_bits-1:0] hex_value_t;

	// Heartbeat half period in clock cycles
	typedef logic [heartbeat_width-1:0] heartbeat_period_t;

	// Half period after reset
	localparam heartbeat_period_t heartbeat_reset_period = 24'd5_000_000;	// About 0.1 s at 50 MHz

	// Unused hex digit pattern
	localparam seg_t seg_dark = '1;	// All segments off

endpackage

/* logic/fpga_top.sv */
// Peripheral subsystem only, so the core, L2 cache, memory, JTAG loader and clock divider sit outside
module fpga_top (
	input logic clk,
	input logic arst_n,
	input io_pkg::io_req_t io_req,
	output io_pkg::io_data_t read_data,
	output logic read_valid,
	input board_pkg::sw_t sw,
	input board_pkg::key_t key_n,
	output board_pkg::red_led_t red_led,
	output logic [board_pkg::num_green_leds-1:0] green_led,
	output board_pkg::seg_t hex0,
	output board_pkg::seg_t hex1,
	output board_pkg::seg_t hex2,
	output board_pkg::seg_t hex3
);
	import board_pkg::*;

	sw_t sw_sync;						// Switches in clk domain
	key_t keys_raw;						// Keys, high when pressed
	key_t keys_sync;					// Keys in clk domain
	logic keys_changed;					// Key vector changed
	key_t key_flags;					// Sticky press flags
	logic hex_load;						// Display load strobe
	hex_value_t hex_value;				// Display value
	logic hex_blank;					// Leading-zero blank enable
	seg_t [num_digits-1:0] segments;	// Digit patterns
	logic period_load;					// Heartbeat load strobe
	heartbeat_period_t period;			// Heartbeat period
	logic blink;						// Heartbeat output

	// Board keys pull low when pressed
	assign keys_raw = ~key_n;

	sync_stage #(.payload_t(sw_t)) u_sw_sync (
		.clk(clk),
		.arst_n(arst_n),
		.async_in(sw),
		.sync_out(sw_sync),
		.changed()		// Switches are polled
	);

	sync_stage #(.payload_t(key_t)) u_key_sync (
		.clk(clk),
		.arst_n(arst_n),
		.async_in(keys_raw),
		.sync_out(keys_sync),
		.changed(keys_changed)
	);

	io_ctrl u_io_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.io_req(io_req),
		.read_data(read_data),
		.read_valid(read_valid),
		.sw(sw_sync),
		.keys(keys_sync),
		.keys_changed(keys_changed),
		.red_led(red_led),
		.key_flags(key_flags),
		.hex_load(hex_load),
		.hex_value(hex_value),
		.hex_blank(hex_blank),
		.period_load(period_load),
		.period(period)
	);

	hex_display u_hex_display (
		.clk(clk),
		.arst_n(arst_n),
		.hex_load(hex_load),
		.hex_value(hex_value),
		.hex_blank(hex_blank),
		.segments(segments)
	);

	heartbeat u_heartbeat (
		.clk(clk),
		.arst_n(arst_n),
		.period_load(period_load),
		.period(period),
		.blink(blink)
	);

	// Digit 0 is the rightmost display
	assign hex0 = segments[0];
	assign hex1 = segments[1];
	assign hex2 = segments[2];
	assign hex3 = segments[3];

	// Blink on top, then sticky flags, then live keys
	assign green_led = {blink, key_flags, keys_sync};

endmodule

/* logic/heartbeat.sv */
// Blink toggles every period plus one cycles, and a zero period is illegal since it would toggle every cycle
module heartbeat (
	input logic clk,
	input logic arst_n,
	input logic period_load,
	input board_pkg::heartbeat_period_t period,
	output logic blink
);
	import board_pkg::*;

	heartbeat_period_t period_q;	// Active half period
	heartbeat_period_t count;		// Cycles left until toggle

	// Down-counter with reload
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			period_q <= heartbeat_reset_period;
			count <= heartbeat_reset_period;
			blink <= 1'b0;
		end
		else if (period_load)
		begin
			period_q <= period;		// New period takes effect now
			count <= period;		// Restart the count
		end
		else if (count == '0)
		begin
			count <= period_q;		// Reload for next half period
			blink <= ~blink;
		end
		else
			count <= count - heartbeat_period_t'(1);
	end

	// The core never programs a zero period
	a_period_nonzero: assert property (
		@(posedge clk) disable iff (!arst_n)
		period_load |-> (period != '0)
	) else $error("heartbeat: zero period loaded");

endmodule

/* logic/hex_display.sv */
// Segments are active low in gfedcba order, and after reset all digits stay dark until the first load
module hex_display (
	input logic clk,
	input logic arst_n,
	input logic hex_load,
	input board_pkg::hex_value_t hex_value,
	input logic hex_blank,
	output board_pkg::seg_t [board_pkg::num_digits-1:0] segments
);
	import board_pkg::*;

	hex_value_t value_q;	// Displayed value
	logic blank_en;			// Leading-zero blanking on
	logic blanked;			// Dark until first load
	logic leading;			// Still inside the leading zeros

	// Standard hex font, active low
	function automatic seg_t encode_nibble(input logic [nibble_bits-1:0] nibble);
		seg_t seg;
		case (nibble)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;	// Lower case b
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;	// Lower case d
			4'he: seg = 7'h06;
			default: seg = 7'h0e;	// F
		endcase
		return seg;
	endfunction

	// Value and mode registers
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			value_q <= '0;		// Blank value
			blank_en <= 1'b1;	// Blanking set
			blanked <= 1'b1;	// Hide the lone zero too
		end
		else if (hex_load)
		begin
			value_q <= hex_value;
			blank_en <= hex_blank;
			blanked <= 1'b0;	// First load lights the display
		end
	end

	// Scan from the top digit down and darken zeros while still leading
	always_comb
	begin
		leading = 1'b1;
		for (int i = num_digits - 1; i >= 0; i--)
		begin
			leading = leading && (value_q[i] == '0);	// Zero and all above zero
			if (blanked || (blank_en && leading && i != 0))
				segments[i] = seg_dark;		// Digit 0 is never blanked by value
			else
				segments[i] = encode_nibble(value_q[i]);
		end
	end

endmodule

/* logic/io_ctrl.sv */
// Single-cycle strobes without back-pressure, write and read never in the same cycle, unmapped reads return zero
module io_ctrl (
	input logic clk,
	input logic arst_n,
	input io_pkg::io_req_t io_req,
	output io_pkg::io_data_t read_data,
	output logic read_valid,
	input board_pkg::sw_t sw,
	input board_pkg::key_t keys,
	input logic keys_changed,
	output board_pkg::red_led_t red_led,
	output board_pkg::key_t key_flags,
	output logic hex_load,
	output board_pkg::hex_value_t hex_value,
	output logic hex_blank,
	output logic period_load,
	output board_pkg::heartbeat_period_t period
);
	import board_pkg::*;
	import io_pkg::*;

	logic wr_red;						// Write to LED register
	logic rd_keys;						// Read of key flags
	hex_value_t hex_shadow;				// Readback of display value
	logic blank_shadow;					// Readback of blank enable
	heartbeat_period_t period_shadow;	// Readback of heartbeat period
	key_t keys_last;					// Keys before the latest change
	key_t key_rise;						// Keys newly pressed this cycle
	io_data_t read_word;				// Read mux output

	// Address decode
	assign wr_red = io_req.write_en && (io_req.address == addr_red_led);
	assign rd_keys = io_req.read_en && (io_req.address == addr_keys);
	assign hex_load = io_req.write_en && (io_req.address == addr_hex);
	assign period_load = io_req.write_en && (io_req.address == addr_heartbeat);

	// Datapath payloads, qualified by the load strobes
	assign hex_value = io_req.write_data[hex_bits-1:0];
	assign hex_blank = io_req.write_data[hex_blank_bit];
	assign period = io_req.write_data[heartbeat_width-1:0];

	// LED register and readback shadows
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red_led <= '0;
			hex_shadow <= '0;
			blank_shadow <= 1'b1;	// Matches display reset
			period_shadow <= heartbeat_reset_period;
		end
		else
		begin
			if (wr_red)
				red_led <= io_req.write_data[num_red_leds-1:0];
			if (hex_load)
			begin
				hex_shadow <= hex_value;
				blank_shadow <= hex_blank;
			end
			if (period_load)
				period_shadow <= period;
		end
	end

	// Rising keys, only on a synchronizer change
	assign key_rise = keys_changed ? (keys & ~keys_last) : '0;

	// Sticky flags, a rise at the clearing edge still sets
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			keys_last <= '0;
			key_flags <= '0;
		end
		else
		begin
			if (keys_changed)
				keys_last <= keys;
			if (rd_keys)
				key_flags <= key_rise;		// Clear on read
			else
				key_flags <= key_flags | key_rise;
		end
	end

	// Read mux
	always_comb
	begin
		read_word = '0;
		case (io_req.address)
			addr_red_led:
				read_word[num_red_leds-1:0] = red_led;
			addr_hex:
			begin
				read_word[hex_bits-1:0] = hex_shadow;
				read_word[hex_blank_bit] = blank_shadow;
			end
			addr_heartbeat:
				read_word[heartbeat_width-1:0] = period_shadow;
			addr_switches:
				read_word[num_switches-1:0] = sw;
			addr_keys:
			begin
				read_word[keys_flag_lsb +: num_keys] = key_flags;	// Value before clear
				read_word[keys_live_lsb +: num_keys] = keys;
			end
			default:
				read_word = '0;		// Unmapped
		endcase
	end

	// Registered read response
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			read_valid <= 1'b0;
			read_data <= '0;
		end
		else
		begin
			read_valid <= io_req.read_en;
			read_data <= io_req.read_en ? read_word : '0;	// Zero when idle
		end
	end

	// Core side bus rule
	a_no_overlap: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(io_req.write_en && io_req.read_en)
	) else $error("io_ctrl: write and read strobes in the same cycle");

endmodule

/* logic/io_pkg.sv */
// Strobe IO bus seen from the core, with no back-pressure and read data returned one cycle after read_en
package io_pkg;

	// Bus widths
	localparam int io_data_width = 32;	// Bus word
	localparam int io_addr_width = 32;	// Byte address

	// Word and address types
	typedef logic [io_data_width-1:0] io_data_t;
	typedef logic [io_addr_width-1:0] io_addr_t;

	// One bus cycle as driven by the core
	typedef struct packed {
		logic write_en;			// Single-cycle write strobe
		logic read_en;			// Single-cycle read strobe
		io_addr_t address;		// Register address
		io_data_t write_data;	// Valid with write_en
	} io_req_t;

	// Address map
	localparam io_addr_t addr_red_led = 32'd0;		// Read and write
	localparam io_addr_t addr_hex = 32'd4;			// Value and blank enable
	localparam io_addr_t addr_heartbeat = 32'd8;	// Blink half period
	localparam io_addr_t addr_switches = 32'd12;	// Read only
	localparam io_addr_t addr_keys = 32'd16;		// Read clears sticky flags

	// Field positions inside the addr_hex word
	localparam int hex_blank_bit = 16;	// Leading-zero blank enable

	// Field positions inside the addr_keys word
	localparam int keys_flag_lsb = 0;	// Sticky press flags
	localparam int keys_live_lsb = 4;	// Live synchronized keys

endpackage

/* logic/sync_stage.sv */
// Each bit is synchronized on its own, so a multi-bit payload may tear for a cycle and suits slow board inputs only
module sync_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input payload_t async_in,
	output payload_t sync_out,
	output logic changed
);

	payload_t meta;			// First stage, may go metastable
	payload_t sync_prev;	// Last synchronized value

	// Two-flop synchronizer plus history register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			meta <= '0;
			sync_out <= '0;
			sync_prev <= '0;
		end
		else
		begin
			meta <= async_in;		// Capture pin
			sync_out <= meta;		// Settled copy
			sync_prev <= sync_out;	// One cycle behind
		end
	end

	// High in the one cycle the output differs from before
	assign changed = (sync_out != sync_prev);

	// The pulse only marks a real change of the synchronized value
	a_changed_real: assert property (
		@(posedge clk) disable iff (!arst_n)
		changed |-> (sync_out != $past(sync_out))
	) else $error("sync_stage: changed pulse without an output change");

endmodule

/* tb/tb_fpga_top.sv */
// Testbench plays the core, and key or switch changes never overlap a bus read so the model stays simple
module tb_fpga_top;
	import board_pkg::*;
	import io_pkg::*;

	localparam int hb_test_period = 20;	// Short blink half period
	localparam int test_cycles = 32 + 64 + 56 + (3 * (hb_test_period + 1) + 16) + 48 + 48;
	localparam int timeout_cycles = 2 * test_cycles;	// Generous margin over all tests

	// Active-high gfedcba font, 0 to F
	localparam logic [6:0] font_on [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
	// Hex words with blank bit 16, chosen to reach every nibble
	localparam io_data_t hex_cases [7] = '{32'h0000_1234, 32'h0001_00a0, 32'h0001_0000,
		32'h0000_0f05, 32'h0000_6789, 32'h0001_cdef, 32'h0001_0b00};

	logic clk;
	logic arst_n;
	io_req_t io_req;
	io_data_t read_data;
	logic read_valid;
	sw_t sw;
	key_t key_n;
	red_led_t red_led;
	logic [num_green_leds-1:0] green_led;
	seg_t hex0;
	seg_t hex1;
	seg_t hex2;
	seg_t hex3;

	red_led_t exp_red = '0;							// LED register model
	hex_value_t exp_hex = '0;						// Display value model
	logic exp_blank = 1'b1;							// Blank enable model
	logic exp_dark = 1'b1;							// Dark until first hex write
	heartbeat_period_t exp_period = heartbeat_reset_period;
	sw_t exp_sw = '0;								// Synchronized switches
	key_t exp_keys = '0;							// Synchronized keys
	key_t exp_flags = '0;							// Sticky flags
	logic exp_valid = 1'b0;							// Read response window
	io_data_t exp_read = '0;						// Read response word
	seg_t [num_digits-1:0] exp_segs;				// Expected digit patterns
	logic lead;										// Inside leading zeros
	int error_count = 0;
	int test_count = 0;
	int test_start = 0;								// Errors before current test
	int cycle_count = 0;
	int hb_age = 0;									// Cycles since load or toggle
	int hb_gap = 0;									// Length of last blink half period
	int hb_toggles = 0;
	logic hb_toggled = 1'b0;						// Toggle seen this cycle
	logic hb_checking = 1'b0;						// Short period loaded
	logic blink_seen = 1'b0;
	int unsigned seed;
	io_data_t rnd;

	fpga_top uut (
		.clk(clk),
		.arst_n(arst_n),
		.io_req(io_req),
		.read_data(read_data),
		.read_valid(read_valid),
		.sw(sw),
		.key_n(key_n),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	always #4 clk = ~clk;	// Period 8

	// Run limit
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	// Blink watched mid-cycle where it is stable
	always @(negedge clk)
	begin
		if (green_led[num_green_leds-1] != blink_seen)
		begin
			hb_gap = hb_age;
			hb_age = 1;		// Toggle edge is the first of the new half period
			hb_toggled = 1'b1;
			hb_toggles = hb_toggles + 1;
		end
		else
		begin
			hb_age = hb_age + 1;
			hb_toggled = 1'b0;
		end
		blink_seen = green_led[num_green_leds-1];
	end

	// Display model, zeros above the first nonzero digit go dark
	always_comb
	begin
		lead = 1'b1;
		for (int i = num_digits - 1; i >= 0; i--)
		begin
			lead = lead && (exp_hex[i] == 4'h0);
			exp_segs[i] = (exp_dark || (exp_blank && lead && i != 0)) ? '1 : ~font_on[exp_hex[i]];
		end
	end

	function automatic void fail_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("CHECK FAILED %s got %h expected %h", name, got, want);
		error_count++;
	endfunction

	// Register word by address map
	function automatic io_data_t expected_word(input io_addr_t addr);
		io_data_t w;
		w = '0;
		case (addr)
			addr_red_led: w[num_red_leds-1:0] = exp_red;
			addr_hex: w[hex_blank_bit:0] = {exp_blank, exp_hex};
			addr_heartbeat: w[heartbeat_width-1:0] = exp_period;
			addr_switches: w[num_switches-1:0] = exp_sw;
			addr_keys: w[7:0] = {exp_keys, exp_flags};	// Live keys above flags
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic bus_write(input io_addr_t addr, input io_data_t data);
		@(posedge clk);
		#1;
		io_req = '{write_en: 1'b1, read_en: 1'b0, address: addr, write_data: data};
		@(posedge clk);
		#1;
		io_req.write_en = 1'b0;	// Write landed at the edge just passed
		case (addr)
			addr_red_led: exp_red = data[num_red_leds-1:0];
			addr_hex:
			begin
				exp_hex = data[hex_bits-1:0];
				exp_blank = data[hex_blank_bit];
				exp_dark = 1'b0;
			end
			addr_heartbeat:
			begin
				exp_period = data[heartbeat_width-1:0];
				hb_age = 0;		// Half period restarts at the load
			end
			default: ;
		endcase
	endtask

	task automatic bus_read(input io_addr_t addr);
		@(posedge clk);
		#1;
		io_req = '{write_en: 1'b0, read_en: 1'b1, address: addr, write_data: '0};
		@(posedge clk);
		#1;
		io_req.read_en = 1'b0;
		exp_read = expected_word(addr);	// Value at the read edge
		exp_valid = 1'b1;
		if (addr == addr_keys)
			exp_flags = '0;
		@(posedge clk);
		#1;
		exp_valid = 1'b0;
		exp_read = '0;
	endtask

	task automatic set_switches(input sw_t pattern);
		@(posedge clk);
		#1;
		sw = pattern;
		repeat (2) @(posedge clk);
		#1;
		exp_sw = pattern;	// Two-flop latency
	endtask

	task automatic set_keys(input key_t pressed);
		key_t rise;
		rise = pressed & ~exp_keys;
		@(posedge clk);
		#1;
		key_n = ~pressed;	// Pins pull low
		repeat (2) @(posedge clk);
		#1;
		exp_keys = pressed;
		@(posedge clk);
		#1;
		exp_flags = exp_flags | rise;	// Flag follows one cycle later
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == test_start)
			$display("Test %s passed", name);
		else
			$display("Test %s failed, %0d checks", name, error_count - test_start);
		test_start = error_count;
	endtask

	a_red_led: assert property (@(posedge clk) disable iff (!arst_n) red_led == exp_red)
		else fail_value("red_led", 32'($sampled(red_led)), 32'(exp_red));
	a_read_valid: assert property (@(posedge clk) disable iff (!arst_n) read_valid == exp_valid)
		else fail_value("read_valid", 32'($sampled(read_valid)), 32'(exp_valid));
	a_read_data: assert property (@(posedge clk) disable iff (!arst_n) read_data == exp_read)
		else fail_value("read_data", $sampled(read_data), exp_read);
	a_hex: assert property (@(posedge clk) disable iff (!arst_n)
		{hex3, hex2, hex1, hex0} == exp_segs)
		else fail_value("hex3..hex0", 32'($sampled({hex3, hex2, hex1, hex0})), 32'(exp_segs));
	a_green: assert property (@(posedge clk) disable iff (!arst_n)
		green_led[7:0] == {exp_flags, exp_keys})
		else fail_value("green_led[7:0]", 32'($sampled(green_led[7:0])),
			32'({exp_flags, exp_keys}));
	a_blink_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!hb_checking |-> green_led[num_green_leds-1] == 1'b0)
		else fail_value("blink", 32'($sampled(green_led[num_green_leds-1])), 32'h0);
	a_blink_gap: assert property (@(posedge clk) disable iff (!arst_n)
		(hb_checking && hb_toggled) |-> hb_gap == int'(exp_period) + 1)
		else fail_value("blink toggle gap", hb_gap, int'(exp_period) + 1);
	a_blink_late: assert property (@(posedge clk) disable iff (!arst_n)
		hb_checking |-> hb_age <= int'(exp_period) + 1)
		else fail_value("blink overdue age", hb_age, int'(exp_period) + 1);

	initial
	begin
		seed = $urandom(81599);	// Fixes the random sequence
		clk = 1'b0;
		arst_n = 1'b0;
		io_req = '0;
		sw = '0;
		key_n = '1;				// No key pressed
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		repeat (3) @(posedge clk);
		bus_read(addr_red_led);
		bus_read(addr_hex);		// Zero value with blank bit set
		bus_read(addr_heartbeat);
		bus_read(addr_keys);
		end_test("reset_state");

		for (int n = 0; n < 8; n++)
		begin
			bus_write(addr_red_led, $urandom());
			bus_read(addr_red_led);
		end
		bus_write(32'h100, $urandom());	// Unmapped write is dropped
		bus_read(32'h100);
		bus_read(addr_red_led);
		bus_read(32'd20);
		end_test("red_led");

		for (int n = 0; n < 9; n++)
		begin
			rnd = (n < 7) ? hex_cases[n] : $urandom();
			bus_write(addr_hex, rnd);
			bus_read(addr_hex);
		end
		end_test("hex_display");

		bus_write(addr_heartbeat, hb_test_period);
		hb_checking = 1'b1;
		hb_toggles = 0;
		while (hb_toggles < 3)
			@(posedge clk);
		bus_read(addr_heartbeat);
		end_test("heartbeat");

		for (int n = 0; n < 6; n++)
		begin
			set_switches(sw_t'($urandom()));
			bus_read(addr_switches);
		end
		end_test("switches");

		set_keys(4'b0101);		// Keys 0 and 2 down
		bus_read(addr_keys);	// Flags come back, then clear
		bus_read(addr_keys);	// Held keys stay clear
		set_keys(4'b0111);
		set_keys(4'b0110);		// Key 0 up
		set_keys(4'b0111);		// Key 0 pressed anew
		bus_read(addr_keys);
		set_keys(4'b0000);
		bus_read(addr_keys);
		end_test("keys");

		$display("Summary: %0d tests run, %0d checks failed", test_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
